// ==== build.f ====
hdl/coreTypesPkg.sv
hdl/branchPkg.sv
hdl/branchResolver.sv
hdl/memOrderReplay.sv
hdl/trapRedirect.sv
hdl/branchSelector.sv
hdl/flushSequencer.sv
hdl/perfCounters.sv
hdl/branchResolveUnit.sv
tests/branchResolveUnitTb.sv

// ==== Bender.yml ====
package:
  name: branch_resolve_unit

sources:
  - hdl/coreTypesPkg.sv
  - hdl/branchPkg.sv
  - hdl/branchResolver.sv
  - hdl/memOrderReplay.sv
  - hdl/trapRedirect.sv
  - hdl/branchSelector.sv
  - hdl/flushSequencer.sv
  - hdl/perfCounters.sv
  - hdl/branchResolveUnit.sv
  - target: test
    files:
      - tests/branchResolveUnitTb.sv

// ==== tests/branchResolveUnitTb.sv ====
module branchResolveUnitTb;

    import coreTypesPkg::*;
    import branchPkg::*;

    localparam int PERIOD = 20;
    localparam int STIM_DELAY = 2;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM = 24;
    localparam SqN TABLE_ROB = 7'h60; // Table sqNs stay inside 0x60..0x1F.

    // Replay or trap strobe, pc is the vector for a trap.
    typedef struct packed {
        logic valid;
        SqN sqN;
        Pc pc;
    } SideReq;

    typedef struct packed {
        logic taken;
        SqN sqN;
        Pc dstPC;
        logic flush;
        logic mispr;
        logic window; // Expected mispredFlush level.
    } Outcome;

    typedef struct packed {
        ResolveReq r0;
        ResolveReq r1;
        SideReq replay;
        SideReq trap;
        SqN robCur;
        Outcome want;
    } Row;

    logic clk;
    logic rst;
    ResolveReq resolve0;
    ResolveReq resolve1;
    logic replayValid;
    SqN replaySqN;
    Pc replayPC;
    SqN replayLoadSqN;
    SqN replayStoreSqN;
    FetchId replayFetchID;
    logic trapValid;
    SqN trapSqN;
    Pc trapVector;
    SqN robCurSqN;
    SqN rnNextSqN;
    BranchProv redirect;
    logic mispredFlush;
    logic [PERF_W-1:0] misprCount;
    logic [PERF_W-1:0] redirectCount;

    Row rows[$];
    logic rowsBuilt;
    logic [31:0] rngState;
    int checks = 0;
    int errors = 0;
    int expMispr = 0;
    int expRedirects = 0;

    branchResolveUnit i_dut (
        .clk(clk),
        .rst(rst),
        .resolve0(resolve0),
        .resolve1(resolve1),
        .replayValid(replayValid),
        .replaySqN(replaySqN),
        .replayPC(replayPC),
        .replayLoadSqN(replayLoadSqN),
        .replayStoreSqN(replayStoreSqN),
        .replayFetchID(replayFetchID),
        .trapValid(trapValid),
        .trapSqN(trapSqN),
        .trapVector(trapVector),
        .robCurSqN(robCurSqN),
        .rnNextSqN(rnNextSqN),
        .redirect(redirect),
        .mispredFlush(mispredFlush),
        .misprCount(misprCount),
        .redirectCount(redirectCount)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic ResolveReq noBranch();
        return '0;
    endfunction

    function automatic ResolveReq branchReq(SqN sqN, logic predTaken, logic actTaken,
                                            Pc target, Pc fallThrough, FetchId fetchID);
        ResolveReq r;
        r = '0;
        r.valid = 1'b1;
        r.sqN = sqN;
        r.loadSqN = sqN;
        r.storeSqN = sqN;
        r.fetchID = fetchID;
        r.history = {1'b0, sqN};
        r.predTaken = predTaken;
        r.actTaken = actTaken;
        r.target = target;
        r.fallThrough = fallThrough;
        return r;
    endfunction

    function automatic SideReq noSide();
        return '0;
    endfunction

    function automatic SideReq sideReq(SqN sqN, Pc pc);
        SideReq s;
        s.valid = 1'b1;
        s.sqN = sqN;
        s.pc = pc;
        return s;
    endfunction

    function automatic Outcome noRedirect(logic window);
        Outcome o;
        o = '0;
        o.window = window;
        return o;
    endfunction

    function automatic Outcome redirectTo(SqN sqN, Pc dst, logic flush, logic mispr,
                                          logic window);
        Outcome o;
        o.taken = 1'b1;
        o.sqN = sqN;
        o.dstPC = dst;
        o.flush = flush;
        o.mispr = mispr;
        o.window = window;
        return o;
    endfunction

    task automatic addRow(ResolveReq r0, ResolveReq r1, SideReq replay, SideReq trap,
                          SqN robCur, Outcome want);
        Row r;
        r.r0 = r0;
        r.r1 = r1;
        r.replay = replay;
        r.trap = trap;
        r.robCur = robCur;
        r.want = want;
        rows.push_back(r);
    endtask

    task automatic addIdles(int count, logic window, SqN robCur);
        for (int i = 0; i < count; i++)
            addRow(noBranch(), noBranch(), noSide(), noSide(), robCur, noRedirect(window));
    endtask

    task automatic buildTable();
        // Correct not-taken branch teaches resolver 0 the target of fetch packet 1.
        addRow(branchReq(7'h61, 1'b0, 1'b0, 32'h2000, 32'h1004, 4'h1), noBranch(),
               noSide(), noSide(), TABLE_ROB, noRedirect(1'b0));
        addRow(branchReq(7'h62, 1'b0, 1'b1, 32'h3000, 32'h1010, 4'h2), noBranch(),
               noSide(), noSide(), TABLE_ROB, redirectTo(7'h62, 32'h3000, 1'b0, 1'b1, 1'b0));
        addIdles(3, 1'b1, TABLE_ROB);
        // Right direction, wrong target.
        addRow(branchReq(7'h63, 1'b1, 1'b1, 32'h2400, 32'h1020, 4'h1), noBranch(),
               noSide(), noSide(), TABLE_ROB, redirectTo(7'h63, 32'h2400, 1'b0, 1'b1, 1'b0));
        addIdles(3, 1'b1, TABLE_ROB);
        addRow(branchReq(7'h64, 1'b1, 1'b1, 32'h2000, 32'h1030, 4'h1),
               branchReq(7'h65, 1'b0, 1'b0, 32'h2800, 32'h1040, 4'h1),
               noSide(), noSide(), TABLE_ROB, noRedirect(1'b0));
        // Oldest of three wins.
        addRow(branchReq(7'h70, 1'b0, 1'b1, 32'h4000, 32'h4004, 4'h4),
               branchReq(7'h68, 1'b1, 1'b0, 32'h5000, 32'h5004, 4'h5),
               sideReq(7'h6C, 32'h6000), noSide(), TABLE_ROB,
               redirectTo(7'h68, 32'h5004, 1'b0, 1'b1, 1'b0));
        addIdles(3, 1'b1, TABLE_ROB);
        addRow(branchReq(7'h02, 1'b1, 1'b0, 32'h4100, 32'h4108, 4'h4),
               branchReq(7'h7E, 1'b0, 1'b1, 32'h5100, 32'h5104, 4'h5),
               sideReq(7'h05, 32'h6100), noSide(), TABLE_ROB,
               redirectTo(7'h7E, 32'h5100, 1'b0, 1'b1, 1'b0)); // 0x7E is older across the wrap.
        addIdles(3, 1'b1, TABLE_ROB);
        addRow(branchReq(7'h66, 1'b0, 1'b1, 32'h4200, 32'h4204, 4'h4), noBranch(),
               sideReq(7'h64, 32'h6200), noSide(), TABLE_ROB,
               redirectTo(7'h64, 32'h6200, 1'b0, 1'b0, 1'b0));
        addIdles(3, 1'b1, TABLE_ROB);
        addRow(branchReq(7'h61, 1'b0, 1'b1, 32'h4300, 32'h4304, 4'h4),
               branchReq(7'h62, 1'b1, 1'b0, 32'h5300, 32'h5304, 4'h5),
               noSide(), sideReq(7'h70, 32'h8000), TABLE_ROB,
               redirectTo(7'h70, 32'h8000, 1'b1, 1'b0, 1'b0));
        addIdles(3, 1'b1, TABLE_ROB);
        // Flush window filtering and restart.
        addRow(branchReq(7'h70, 1'b1, 1'b0, 32'h4400, 32'h4404, 4'h4), noBranch(),
               noSide(), noSide(), TABLE_ROB, redirectTo(7'h70, 32'h4404, 1'b0, 1'b1, 1'b0));
        addRow(noBranch(), branchReq(7'h75, 1'b0, 1'b1, 32'h5400, 32'h5404, 4'h5),
               noSide(), noSide(), TABLE_ROB, noRedirect(1'b1));
        addRow(noBranch(), branchReq(7'h6A, 1'b0, 1'b1, 32'h5500, 32'h5504, 4'h5),
               noSide(), noSide(), TABLE_ROB, redirectTo(7'h6A, 32'h5500, 1'b0, 1'b1, 1'b1));
        addIdles(1, 1'b1, TABLE_ROB);
        addRow(noBranch(), noBranch(), sideReq(7'h6B, 32'h6300), noSide(), TABLE_ROB,
               noRedirect(1'b1));
        addIdles(1, 1'b1, TABLE_ROB);
        addIdles(1, 1'b0, TABLE_ROB);
        addRow(branchReq(7'h7A, 1'b0, 1'b1, 32'h4600, 32'h4604, 4'h4), noBranch(),
               noSide(), noSide(), TABLE_ROB, redirectTo(7'h7A, 32'h4600, 1'b0, 1'b1, 1'b0));
        addIdles(3, 1'b1, TABLE_ROB);
        addIdles(1, 1'b0, TABLE_ROB);
    endtask

    task automatic addRandomRows();
        ResolveReq req;
        SqN sqN;
        SqN robCur;
        logic slot;
        logic predTaken;
        logic actTaken;
        logic mispr;
        Pc target;
        Pc fallThrough;
        Pc dst;
        Outcome want;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rngState = xorshift(rngState);
            sqN = rngState[6:0];
            slot = rngState[7];
            predTaken = rngState[8];
            actTaken = predTaken ? 1'b0 : rngState[9]; // Taken/taken would need a trained target.
            rngState = xorshift(rngState);
            target = {rngState[31:2], 2'b00};
            fallThrough = target ^ 32'h0001_0000;
            mispr = predTaken != actTaken;
            dst = actTaken ? target : fallThrough;
            robCur = sqN - SqN'(8);
            want = mispr ? redirectTo(sqN, dst, 1'b0, 1'b1, 1'b0) : noRedirect(1'b0);
            req = branchReq(sqN, predTaken, actTaken, target, fallThrough, 4'h3);
            if (slot)
                addRow(noBranch(), req, noSide(), noSide(), robCur, want);
            else
                addRow(req, noBranch(), noSide(), noSide(), robCur, want);
            addIdles(FLUSH_CYCLES, mispr, robCur);
            addIdles(1, 1'b0, robCur);
        end
    endtask

    task automatic driveRow(Row r);
        resolve0 = r.r0;
        resolve1 = r.r1;
        replayValid = r.replay.valid;
        replaySqN = r.replay.sqN;
        replayPC = r.replay.pc;
        replayLoadSqN = r.replay.sqN;
        replayStoreSqN = r.replay.sqN;
        replayFetchID = r.replay.sqN[3:0];
        trapValid = r.trap.valid;
        trapSqN = r.trap.sqN;
        trapVector = r.trap.pc;
        robCurSqN = r.robCur;
        rnNextSqN = r.robCur + SqN'(64); // 64 ops in flight.
    endtask

    task automatic compare(string where, string name, logic [31:0] got, logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL %s: %s = 0x%h, expected 0x%h", where, name, got, want);
        end
    endtask

    task automatic checkRow(int idx, Outcome want);
        string where;
        where = $sformatf("row %0d", idx);
        compare(where, "redirect.taken", redirect.taken, want.taken);
        if (want.taken) begin
            compare(where, "redirect.sqN", redirect.sqN, want.sqN);
            compare(where, "redirect.dstPC", redirect.dstPC, want.dstPC);
            compare(where, "redirect.flush", redirect.flush, want.flush);
        end
        compare(where, "branchMispr", i_dut.branchMispr, want.mispr);
        compare(where, "mispredFlush", mispredFlush, want.window);
    endtask

    initial begin
        rowsBuilt = 1'b0;
        rst = 1'b1;
        rngState = 32'd85312;
        driveRow('0);
        buildTable();
        addRandomRows();
        foreach (rows[k]) begin
            expMispr += rows[k].want.mispr;
            expRedirects += rows[k].want.taken;
        end
        rowsBuilt = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #STIM_DELAY;
        rst = 1'b0;
        foreach (rows[k]) begin
            driveRow(rows[k]);
            @(posedge clk);
            #1;
            checkRow(k, rows[k].want);
            #(STIM_DELAY - 1);
        end
        compare("end of run", "misprCount", misprCount, expMispr);
        compare("end of run", "redirectCount", redirectCount, expRedirects);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // One cycle per row plus reset and some slack.
    initial begin
        wait (rowsBuilt);
        #((RESET_CYCLES + rows.size() + 10) * PERIOD);
        $display("Timeout: the run did not reach its end in the expected time.");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== hdl/branchResolveUnit.sv ====
module branchResolveUnit (
    input  logic                         clk,
    input  logic                         rst,
    input  branchPkg::ResolveReq         resolve0,
    input  branchPkg::ResolveReq         resolve1,
    input  logic                         replayValid,
    input  coreTypesPkg::SqN             replaySqN,
    input  coreTypesPkg::Pc              replayPC,
    input  coreTypesPkg::SqN             replayLoadSqN,
    input  coreTypesPkg::SqN             replayStoreSqN,
    input  coreTypesPkg::FetchId         replayFetchID,
    input  logic                         trapValid,
    input  coreTypesPkg::SqN             trapSqN,
    input  coreTypesPkg::Pc              trapVector,
    input  coreTypesPkg::SqN             robCurSqN,
    input  coreTypesPkg::SqN             rnNextSqN,
    output branchPkg::BranchProv         redirect,
    output logic                         mispredFlush,
    output logic [branchPkg::PERF_W-1:0] misprCount,
    output logic [branchPkg::PERF_W-1:0] redirectCount
);

    import branchPkg::*;

    BranchProv provs [NUM_BRANCHES-1:0]; // Slot 3 is the trap.
    logic branchMispr;

    branchResolver i_resolver0 (.clk, .rst, .req(resolve0), .prov(provs[0]));
    branchResolver i_resolver1 (.clk, .rst, .req(resolve1), .prov(provs[1]));

    memOrderReplay i_replay (
        .clk, .rst,
        .valid(replayValid),
        .sqN(replaySqN),
        .pc(replayPC),
        .loadSqN(replayLoadSqN),
        .storeSqN(replayStoreSqN),
        .fetchID(replayFetchID),
        .prov(provs[2])
    );

    trapRedirect i_trap (
        .clk, .rst,
        .valid(trapValid),
        .sqN(trapSqN),
        .vector(trapVector),
        .prov(provs[SLOT_TRAP])
    );

    branchSelector i_selector (
        .clk, .rst,
        .branches(provs),
        .robCurSqN, .rnNextSqN,
        .mispredFlush,
        .branch(redirect),
        .branchMispr
    );

    flushSequencer i_flushSeq (.clk, .rst, .redirectTaken(redirect.taken), .mispredFlush);

    perfCounters i_perf (
        .clk, .rst,
        .branchMispr,
        .redirectTaken(redirect.taken),
        .misprCount,
        .redirectCount
    );

endmodule

// ==== hdl/perfCounters.sv ====
module perfCounters (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         branchMispr,
    input  logic                         redirectTaken,
    output logic [branchPkg::PERF_W-1:0] misprCount,
    output logic [branchPkg::PERF_W-1:0] redirectCount
);

    import branchPkg::*;

    // Both counters stick at all ones.
    always_ff @(posedge clk) begin
        if (rst) begin
            misprCount <= '0;
            redirectCount <= '0;
        end else begin
            if (branchMispr && misprCount != '1)
                misprCount <= misprCount + 1'b1;
            if (redirectTaken && redirectCount != '1)
                redirectCount <= redirectCount + 1'b1;
        end
    end

    mispredIsRedirect: assert property (
        @(posedge clk) disable iff (rst) branchMispr |-> redirectTaken
    );

endmodule

// ==== hdl/flushSequencer.sv ====
module flushSequencer (
    input  logic clk,
    input  logic rst,
    input  logic redirectTaken,
    output logic mispredFlush
);

    import branchPkg::*;

    localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else if (redirectTaken)
            count <= CNT_W'(FLUSH_CYCLES); // Restart on every redirect.
        else if (count != '0)
            count <= count - 1'b1;
    end

    assign mispredFlush = count != '0;

endmodule

// ==== hdl/branchSelector.sv ====
module branchSelector (
    input  logic                  clk,
    input  logic                  rst,
    input  branchPkg::BranchProv  branches [branchPkg::NUM_BRANCHES-1:0],
    input  coreTypesPkg::SqN      robCurSqN,
    input  coreTypesPkg::SqN      rnNextSqN,
    input  logic                  mispredFlush,
    output branchPkg::BranchProv  branch,
    output logic                  branchMispr
);

    import coreTypesPkg::*;
    import branchPkg::*;

    SqN mispredFlushSqN;
    logic [NUM_BRANCHES-1:0] eligible;

    // During a flush only something older than the flushed op may redirect.
    always_comb begin
        for (int i = 0; i < NUM_BRANCHES; i++) begin
            eligible[i] = branches[i].taken &&
                (!mispredFlush || isOlder(branches[i].sqN, mispredFlushSqN));
        end
    end

    always_comb begin
        branch = '0;
        branchMispr = 1'b0;

        for (int i = 0; i < SLOT_TRAP; i++) begin
            if (eligible[i] && (!branch.taken || isOlder(branches[i].sqN, branch.sqN))) begin
                branch = branches[i];
                branch.flush = 1'b0;
                branchMispr = i < NUM_MISPR_SLOTS;
            end
        end

        // Trap wins regardless of age.
        if (eligible[SLOT_TRAP]) begin
            branch = branches[SLOT_TRAP];
            branchMispr = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            mispredFlushSqN <= '0;
        else if (branch.taken)
            mispredFlushSqN <= branch.sqN;
    end

    // A redirect must point into the window of in-flight instructions.
    sqNInWindow: assert property (
        @(posedge clk) disable iff (rst)
        branch.taken |-> !isOlder(branch.sqN, robCurSqN) && isOlder(branch.sqN, rnNextSqN)
    );

endmodule

// ==== hdl/trapRedirect.sv ====
module trapRedirect (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  coreTypesPkg::SqN      sqN,
    input  coreTypesPkg::Pc       vector,
    output branchPkg::BranchProv  prov
);

    import branchPkg::*;

    always_ff @(posedge clk) begin
        prov.flush <= 1'b1;
        prov.dstPC <= vector;
        prov.sqN <= sqN;
        // Nothing younger survives, so the LSQ restarts at the trapping op.
        prov.loadSqN <= sqN;
        prov.storeSqN <= sqN;
        prov.fetchID <= '0;
        prov.history <= '0;
        if (rst)
            prov.taken <= 1'b0;
        else
            prov.taken <= valid;
    end

    // Commit traps one instruction at a time.
    noBackToBackTrap: assert property (
        @(posedge clk) disable iff (rst) prov.taken |=> !prov.taken
    );

endmodule

// ==== hdl/memOrderReplay.sv ====
module memOrderReplay (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  coreTypesPkg::SqN      sqN,
    input  coreTypesPkg::Pc       pc,
    input  coreTypesPkg::SqN      loadSqN,
    input  coreTypesPkg::SqN      storeSqN,
    input  coreTypesPkg::FetchId  fetchID,
    output branchPkg::BranchProv  prov
);

    import branchPkg::*;

    always_ff @(posedge clk) begin
        prov.flush <= 1'b0;
        prov.dstPC <= pc; // Re-fetch the load itself.
        prov.sqN <= sqN;
        prov.loadSqN <= loadSqN;
        prov.storeSqN <= storeSqN;
        prov.fetchID <= fetchID;
        prov.history <= '0;
        if (rst)
            prov.taken <= 1'b0;
        else
            prov.taken <= valid;
    end

endmodule

// ==== hdl/branchResolver.sv ====
module branchResolver (
    input  logic                  clk,
    input  logic                  rst,
    input  branchPkg::ResolveReq  req,
    output branchPkg::BranchProv  prov
);

    import coreTypesPkg::*;

    logic dirWrong;
    logic targetWrong;
    logic mispredict;

    // Last target seen correct for this fetch packet stands in for the prediction.
    Pc predTarget;

    always_comb begin
        dirWrong = req.predTaken != req.actTaken;
        targetWrong = req.predTaken && req.actTaken && (req.target != predTarget);
        mispredict = req.valid && (dirWrong || targetWrong);
    end

    // Predicted target, remembered per fetch packet.
    Pc predTargets [2**FETCH_ID_W];

    always_ff @(posedge clk) begin
        if (req.valid && !mispredict)
            predTargets[req.fetchID] <= req.target;
    end

    assign predTarget = predTargets[req.fetchID];

    always_ff @(posedge clk) begin
        prov.flush <= 1'b0;
        prov.dstPC <= req.actTaken ? req.target : req.fallThrough;
        prov.sqN <= req.sqN;
        prov.loadSqN <= req.loadSqN;
        prov.storeSqN <= req.storeSqN;
        prov.fetchID <= req.fetchID;
        prov.history <= req.history;
        if (rst)
            prov.taken <= 1'b0;
        else
            prov.taken <= mispredict;
    end

    // Branches never request a full flush, only traps do.
    noFlushFromBranch: assert property (
        @(posedge clk) disable iff (rst) prov.taken |-> !prov.flush
    );

endmodule

// ==== hdl/branchPkg.sv ====
package branchPkg;

    import coreTypesPkg::*;

    localparam int NUM_BRANCHES = 4;
    localparam int SLOT_TRAP = 3;
    localparam int NUM_MISPR_SLOTS = 2; // Slots below this count as mispredicts.
    localparam int FLUSH_CYCLES = 3;
    localparam int PERF_W = 16;

    // One redirect proposal towards the front end.
    typedef struct packed {
        logic taken;
        logic flush;        // Whole-pipeline flush, traps only.
        Pc dstPC;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        FetchId fetchID;
        BrHistory history;
    } BranchProv;

    // One branch as it leaves the integer unit.
    typedef struct packed {
        logic valid;
        SqN sqN;
        SqN loadSqN;
        SqN storeSqN;
        FetchId fetchID;
        BrHistory history;
        logic predTaken;
        logic actTaken;
        Pc target;
        Pc fallThrough;
    } ResolveReq;

endpackage

// ==== hdl/coreTypesPkg.sv ====
package coreTypesPkg;

    localparam int SQN_W = 7;
    localparam int PC_W = 32;
    localparam int FETCH_ID_W = 4;
    localparam int HISTORY_W = 8;

    typedef logic [SQN_W-1:0] SqN;
    typedef logic [PC_W-1:0] Pc;
    typedef logic [FETCH_ID_W-1:0] FetchId;
    typedef logic [HISTORY_W-1:0] BrHistory;

    // Wraparound age compare. True when a is older than b.
    function automatic logic isOlder(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return diff[SQN_W-1];
    endfunction

endpackage
